//--- logic/spill_params.svh
`ifndef SPILL_PARAMS_SVH
`define SPILL_PARAMS_SVH

// External SRAM bus.
`define SRAM_ADDR_W 18
`define SRAM_DATA_W 16

// Mix side sizes.
`define MIX_WORD_W 31
`define MIX_ADDR_W 12
`define MIX_DEPTH 4096

// Block layout in the SRAM.
`define BLOCK_W 10
`define BLOCK_WORDS 6
`define BLOCK_STRIDE_LOG2 7

// Host bus and register map.
`define AXI_ADDR_W 16
`define AXI_DATA_W 32
`define REG_CTRL 'h0000
`define REG_BLOCK 'h0004
`define REG_MIX_ADDR 'h0008
`define REG_STATUS 'h000C
`define MIX_WINDOW_BASE 'h4000

`endif

//--- logic/sram_pkg.sv
`default_nettype none

`include "spill_params.svh"

package sram_pkg;

	typedef logic [`SRAM_ADDR_W-1:0] sram_addr_t;
	typedef logic [`SRAM_DATA_W-1:0] sram_data_t;

	// All three strobes are active low.
	typedef struct packed {
		logic cen;
		logic oen;
		logic wen;
	} sram_ctrl_s;

endpackage

`default_nettype wire

//--- logic/mix_pkg.sv
`default_nettype none

`include "spill_params.svh"

package mix_pkg;

	typedef logic [`MIX_WORD_W-1:0] mix_word_t;
	typedef logic [`MIX_ADDR_W-1:0] mix_addr_t;
	typedef logic [`BLOCK_W-1:0] block_num_t;

	// Host register bus.
	typedef logic [`AXI_ADDR_W-1:0] reg_addr_t;
	typedef logic [`AXI_DATA_W-1:0] reg_data_t;

	typedef enum logic [1:0] {
		RESP_OKAY = 2'b00,
		RESP_SLVERR = 2'b10
	} axi_resp_e;

	typedef enum logic {
		XFER_SPILL = 1'b0,
		XFER_FILL = 1'b1
	} xfer_dir_e;

	typedef struct packed {
		logic valid;
		xfer_dir_e dir;
		block_num_t block;
		mix_addr_t mix_addr;
	} xfer_cmd_s;

	// One port request into the mix buffer.
	typedef struct packed {
		logic re;
		logic we;
		mix_addr_t addr;
		mix_word_t wdata;
	} buf_req_s;

	typedef enum logic [1:0] {
		IDLE,
		SETUP,
		MOVE
	} mover_state_e;

endpackage

`default_nettype wire

//--- logic/block_mover.sv
`timescale 1ns/1ps
`default_nettype none

`include "spill_params.svh"

module block_mover
	import sram_pkg::*;
	import mix_pkg::*;
(
	input logic clk,
	input logic reset,
	input xfer_cmd_s cmd,
	output logic busy,
	output buf_req_s buf_req,
	input mix_word_t buf_rdata,
	output sram_addr_t sram_addr,
	output sram_ctrl_s sram_ctrl,
	inout wire sram_data_t sram_data
);

	localparam int CNT_W = $clog2(`BLOCK_WORDS + 1);
	localparam int HIGH_W = `MIX_WORD_W - `SRAM_DATA_W;

	mover_state_e state;
	logic setup_cnt;
	logic [1:0] phase;
	logic [CNT_W-1:0] word_cnt;
	logic [CNT_W-1:0] buf_idx;
	xfer_dir_e dir_q;
	block_num_t block_q;
	mix_addr_t mix_addr_q;
	sram_data_t low_q;
	sram_data_t wr_half;
	logic spill_move;
	logic fill_move;
	logic last_word;

	assign busy = (state != IDLE);
	assign spill_move = (state == MOVE) && (dir_q == XFER_SPILL);
	assign fill_move = (state == MOVE) && (dir_q == XFER_FILL);
	assign last_word = (word_cnt == CNT_W'(`BLOCK_WORDS - 1));

	// Two setup cycles, then four phases per mix word.
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
			setup_cnt <= 1'b0;
			phase <= 2'd0;
			word_cnt <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (cmd.valid) begin
						state <= SETUP;
						setup_cnt <= 1'b0;
						phase <= 2'd0;
						word_cnt <= '0;
					end
				end
				SETUP: begin
					setup_cnt <= 1'b1;
					if (setup_cnt)
						state <= MOVE;
				end
				MOVE: begin
					phase <= phase + 2'd1;
					if (phase == 2'd3) begin
						word_cnt <= word_cnt + CNT_W'(1);
						if (last_word)
							state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && cmd.valid) begin
			dir_q <= cmd.dir;
			block_q <= cmd.block;
			mix_addr_q <= cmd.mix_addr;
		end
		// The low half has had a full cycle on the bus by now.
		if (fill_move && phase == 2'd1)
			low_q <= sram_data;
	end

	// A spill fetches the next word in phase 3, so its data lands in phase 0.
	always_comb begin
		buf_idx = spill_move ? word_cnt + CNT_W'(1) : word_cnt;
		buf_req.re = (dir_q == XFER_SPILL)
			&& ((state == SETUP && setup_cnt) || (spill_move && phase == 2'd3 && !last_word));
		buf_req.we = fill_move && (phase == 2'd3);
		buf_req.addr = mix_addr_q + mix_addr_t'(buf_idx);
		buf_req.wdata = {sram_data[HIGH_W-1:0], low_q};
	end

	// Phase bit 1 picks the odd location of the pair.
	assign sram_addr = (sram_addr_t'(block_q) << `BLOCK_STRIDE_LOG2)
		| sram_addr_t'({word_cnt, phase[1]});
	assign sram_ctrl.cen = (state != MOVE);
	assign sram_ctrl.oen = !fill_move;
	assign sram_ctrl.wen = !(spill_move && !phase[0]);

	// The buffer holds its read data, so the word is still there for the upper half.
	assign wr_half = phase[1] ? sram_data_t'(buf_rdata[`MIX_WORD_W-1:`SRAM_DATA_W])
		: buf_rdata[`SRAM_DATA_W-1:0];
	assign sram_data = spill_move ? wr_half : 'z;

	assert property (@(posedge clk) disable iff (reset)
		!sram_ctrl.wen |-> !sram_ctrl.cen && !$isunknown(wr_half))
		else $error("SRAM write strobe low without chip enable or with an unknown halfword");

	assert property (@(posedge clk) disable iff (reset) busy |-> !cmd.valid)
		else $error("transfer command arrived while the mover was busy");

endmodule

`default_nettype wire

//--- logic/mix_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "spill_params.svh"

module mix_buffer
	import mix_pkg::*;
(
	input logic clk,
	input buf_req_s host_req,
	output mix_word_t host_rdata,
	input buf_req_s mover_req,
	output mix_word_t mover_rdata
);

	mix_word_t mem [`MIX_DEPTH];
	logic host_blocked;

	// On a shared address the mover write lands and the host write is dropped.
	assign host_blocked = mover_req.we && (mover_req.addr == host_req.addr);

	always_ff @(posedge clk) begin
		if (mover_req.we)
			mem[mover_req.addr] <= mover_req.wdata;
		if (host_req.we && !host_blocked)
			mem[host_req.addr] <= host_req.wdata;
	end

	// Read data stays put until the next read on that port.
	always_ff @(posedge clk) begin
		if (host_req.re)
			host_rdata <= mem[host_req.addr];
		if (mover_req.re)
			mover_rdata <= mem[mover_req.addr];
	end

endmodule

`default_nettype wire

//--- logic/spill_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "spill_params.svh"

module spill_regs
	import mix_pkg::*;
(
	input logic clk,
	input logic reset,
	input reg_addr_t awaddr,
	input logic awvalid,
	output logic awready,
	input reg_data_t wdata,
	input logic [`AXI_DATA_W/8-1:0] wstrb,
	input logic wvalid,
	output logic wready,
	output axi_resp_e bresp,
	output logic bvalid,
	input logic bready,
	input reg_addr_t araddr,
	input logic arvalid,
	output logic arready,
	output reg_data_t rdata,
	output axi_resp_e rresp,
	output logic rvalid,
	input logic rready,
	input logic busy,
	output xfer_cmd_s cmd,
	output buf_req_s buf_req,
	input mix_word_t buf_rdata
);

	localparam reg_addr_t WIN_BASE = reg_addr_t'(`MIX_WINDOW_BASE);
	localparam reg_addr_t WIN_SIZE = reg_addr_t'(4 * `MIX_DEPTH);

	block_num_t block_q;
	mix_addr_t mix_addr_q;
	reg_addr_t aw_offs;
	reg_addr_t ar_offs;
	reg_data_t wmask;
	reg_data_t reg_rdata;
	axi_resp_e reg_rresp;
	logic aw_ctrl;
	logic aw_block;
	logic aw_mix;
	logic aw_win;
	logic ar_win;
	logic wr_fire;
	logic wr_err;
	logic win_wr;
	logic start_ok;
	logic rd_pend;

	// Offsets below the base wrap to large values and miss the window.
	assign aw_offs = awaddr - WIN_BASE;
	assign ar_offs = araddr - WIN_BASE;
	assign aw_win = (aw_offs < WIN_SIZE);
	assign ar_win = (ar_offs < WIN_SIZE);

	always_comb begin
		aw_ctrl = (awaddr == reg_addr_t'(`REG_CTRL));
		aw_block = (awaddr == reg_addr_t'(`REG_BLOCK));
		aw_mix = (awaddr == reg_addr_t'(`REG_MIX_ADDR));
		wmask = {{8{wstrb[3]}}, {8{wstrb[2]}}, {8{wstrb[1]}}, {8{wstrb[0]}}};
		wr_err = !(aw_ctrl || aw_block || aw_mix || aw_win)
			|| (aw_ctrl && (busy || (wdata[0] && wdata[1])))
			|| (aw_win && wstrb != '1);
	end

	// Address and data are taken together, and only with no response pending.
	assign wr_fire = awvalid && wvalid && !bvalid;
	assign awready = wr_fire;
	assign wready = wr_fire;
	assign win_wr = wr_fire && aw_win && !wr_err;
	assign start_ok = wr_fire && aw_ctrl && !wr_err && wstrb[0] && (wdata[0] || wdata[1]);

	always_ff @(posedge clk) begin
		if (reset) begin
			block_q <= '0;
			mix_addr_q <= '0;
		end else if (wr_fire && !wr_err) begin
			if (aw_block)
				block_q <= block_num_t'((reg_data_t'(block_q) & ~wmask) | (wdata & wmask));
			if (aw_mix)
				mix_addr_q <= mix_addr_t'((reg_data_t'(mix_addr_q) & ~wmask) | (wdata & wmask));
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			bvalid <= 1'b0;
		else if (wr_fire)
			bvalid <= 1'b1;
		else if (bready)
			bvalid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (wr_fire)
			bresp <= wr_err ? RESP_SLVERR : RESP_OKAY;
	end

	// The command pulses for one cycle. Bit 1 of CTRL selects a fill.
	always_ff @(posedge clk) begin
		cmd.dir <= wdata[1] ? XFER_FILL : XFER_SPILL;
		cmd.block <= block_q;
		cmd.mix_addr <= mix_addr_q;
		if (reset)
			cmd.valid <= 1'b0;
		else
			cmd.valid <= start_ok;
	end

	// The host port is shared, so a window read waits out a window write.
	assign arready = arvalid && !rvalid && !rd_pend && !win_wr;

	always_comb begin
		reg_rdata = '0;
		reg_rresp = RESP_OKAY;
		case (araddr)
			reg_addr_t'(`REG_CTRL): reg_rdata = '0;
			reg_addr_t'(`REG_BLOCK): reg_rdata = reg_data_t'(block_q);
			reg_addr_t'(`REG_MIX_ADDR): reg_rdata = reg_data_t'(mix_addr_q);
			reg_addr_t'(`REG_STATUS): reg_rdata = reg_data_t'(busy);
			default: reg_rresp = RESP_SLVERR;
		endcase
	end

	always_comb begin
		buf_req.we = win_wr;
		buf_req.re = arready && ar_win;
		buf_req.addr = win_wr ? aw_offs[`MIX_ADDR_W+1:2] : ar_offs[`MIX_ADDR_W+1:2];
		buf_req.wdata = wdata[`MIX_WORD_W-1:0];
	end

	// Registers answer in one cycle; the window needs one more for the buffer read.
	always_ff @(posedge clk) begin
		if (reset) begin
			rvalid <= 1'b0;
			rd_pend <= 1'b0;
		end else begin
			rd_pend <= arready && ar_win;
			if ((arready && !ar_win) || rd_pend)
				rvalid <= 1'b1;
			else if (rready)
				rvalid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (arready && !ar_win) begin
			rdata <= reg_rdata;
			rresp <= reg_rresp;
		end else if (rd_pend) begin
			rdata <= reg_data_t'(buf_rdata);
			rresp <= RESP_OKAY;
		end
	end

	assert property (@(posedge clk) disable iff (reset) $rose(cmd.valid) |-> !busy)
		else $error("transfer started while the mover was busy");

endmodule

`default_nettype wire

//--- logic/mix_spill_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "spill_params.svh"

module mix_spill_top
	import sram_pkg::*;
	import mix_pkg::*;
(
	input logic clk,
	input logic reset,
	input reg_addr_t awaddr,
	input logic awvalid,
	output logic awready,
	input reg_data_t wdata,
	input logic [`AXI_DATA_W/8-1:0] wstrb,
	input logic wvalid,
	output logic wready,
	output axi_resp_e bresp,
	output logic bvalid,
	input logic bready,
	input reg_addr_t araddr,
	input logic arvalid,
	output logic arready,
	output reg_data_t rdata,
	output axi_resp_e rresp,
	output logic rvalid,
	input logic rready,
	output sram_addr_t sram_addr,
	output sram_ctrl_s sram_ctrl,
	inout wire sram_data_t sram_data
);

	xfer_cmd_s cmd;
	logic busy;
	buf_req_s host_req;
	buf_req_s mover_req;
	mix_word_t host_rdata;
	mix_word_t mover_rdata;

	spill_regs spill_regs_i (
		.clk(clk),
		.reset(reset),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.busy(busy),
		.cmd(cmd),
		.buf_req(host_req),
		.buf_rdata(host_rdata)
	);

	mix_buffer mix_buffer_i (
		.clk(clk),
		.host_req(host_req),
		.host_rdata(host_rdata),
		.mover_req(mover_req),
		.mover_rdata(mover_rdata)
	);

	block_mover block_mover_i (
		.clk(clk),
		.reset(reset),
		.cmd(cmd),
		.busy(busy),
		.buf_req(mover_req),
		.buf_rdata(mover_rdata),
		.sram_addr(sram_addr),
		.sram_ctrl(sram_ctrl),
		.sram_data(sram_data)
	);

endmodule

`default_nettype wire

//--- tests/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
	parameter int PERIOD = 40
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

endmodule

`default_nettype wire

//--- tests/sram_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "spill_params.svh"

module sram_model
	import sram_pkg::*;
(
	input sram_addr_t addr,
	input sram_ctrl_s ctrl,
	inout wire sram_data_t data
);

	sram_data_t mem [2**`SRAM_ADDR_W];
	logic write_strobe;
	logic read_en;

	assign write_strobe = ctrl.wen;
	assign read_en = !ctrl.cen && !ctrl.oen && ctrl.wen;
	assign data = read_en ? mem[addr] : 'z;

	// Data is latched as the write strobe rises, as on an asynchronous SRAM.
	always @(posedge write_strobe) begin
		if (ctrl.cen == 1'b0)
			mem[addr] = data;
	end

endmodule

`default_nettype wire

//--- tests/mix_spill_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "spill_params.svh"

module mix_spill_tb
	import sram_pkg::*;
	import mix_pkg::*;
();

	localparam int CLK_PERIOD = 40;
	// Each test needs a few dozen AXI transactions of about four cycles and up to two
	// 26-cycle transfers, so 5000 cycles leave a wide margin.
	localparam int TIMEOUT_CYCLES = 5000;

	logic clk;
	logic reset;
	reg_addr_t awaddr;
	logic awvalid;
	logic awready;
	reg_data_t wdata;
	logic [`AXI_DATA_W/8-1:0] wstrb;
	logic wvalid;
	logic wready;
	axi_resp_e bresp;
	logic bvalid;
	logic bready;
	reg_addr_t araddr;
	logic arvalid;
	logic arready;
	reg_data_t rdata;
	axi_resp_e rresp;
	logic rvalid;
	logic rready;
	sram_addr_t sram_addr;
	sram_ctrl_s sram_ctrl;
	wire sram_data_t sram_data;

	string test_name;
	logic [31:0] rng_state;
	mix_word_t spill_words [`BLOCK_WORDS];

	tb_clock #(.PERIOD(CLK_PERIOD)) tb_clock_i (.clk(clk));

	sram_model sram_model_i (.addr(sram_addr), .ctrl(sram_ctrl), .data(sram_data));

	mix_spill_top mix_spill_top_i (
		.clk(clk),
		.reset(reset),
		.awaddr(awaddr),
		.awvalid(awvalid),
		.awready(awready),
		.wdata(wdata),
		.wstrb(wstrb),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bvalid(bvalid),
		.bready(bready),
		.araddr(araddr),
		.arvalid(arvalid),
		.arready(arready),
		.rdata(rdata),
		.rresp(rresp),
		.rvalid(rvalid),
		.rready(rready),
		.sram_addr(sram_addr),
		.sram_ctrl(sram_ctrl),
		.sram_data(sram_data)
	);

	task automatic fail_now(input string line);
		$display("%s", line);
		$display("Finished with errors");
		$fatal(1, "Stopped at the first error.");
	endtask

	task automatic check_word(input string what, input mix_word_t exp, input mix_word_t act);
		if (act !== exp)
			fail_now($sformatf("FAILED %s (%s): expected %h, actual %h", test_name, what, exp, act));
	endtask

	task automatic check_sram(input string what, input sram_data_t exp, input sram_data_t act);
		if (act !== exp)
			fail_now($sformatf("FAILED %s (%s): expected %h, actual %h", test_name, what, exp, act));
	endtask

	task automatic check_resp(input string what, input axi_resp_e exp, input axi_resp_e act);
		if (act !== exp)
			fail_now($sformatf("FAILED %s (%s): expected %b, actual %b", test_name, what, exp, act));
	endtask

	function automatic logic [31:0] next_random();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	function automatic reg_addr_t win_addr(input mix_addr_t idx);
		return reg_addr_t'(`MIX_WINDOW_BASE + 4 * int'(idx));
	endfunction

	// Blocks sit at block number times 128 in the SRAM.
	function automatic sram_addr_t block_base(input block_num_t b);
		return sram_addr_t'(int'(b) * (1 << `BLOCK_STRIDE_LOG2));
	endfunction

	task automatic axi_write(input reg_addr_t addr, input reg_data_t data, output axi_resp_e resp);
		@(negedge clk);
		awaddr = addr;
		awvalid = 1'b1;
		wdata = data;
		wstrb = '1;
		wvalid = 1'b1;
		bready = 1'b1;
		do @(posedge clk); while (!awready);
		if (wready !== 1'b1)
			fail_now($sformatf("Write to %h in %s took the address without the data.",
				addr, test_name));
		@(negedge clk);
		awvalid = 1'b0;
		wvalid = 1'b0;
		do @(posedge clk); while (!bvalid);
		resp = bresp;
		@(negedge clk);
		bready = 1'b0;
	endtask

	task automatic axi_read(input reg_addr_t addr, output reg_data_t data, output axi_resp_e resp);
		@(negedge clk);
		araddr = addr;
		arvalid = 1'b1;
		rready = 1'b1;
		do @(posedge clk); while (!arready);
		@(negedge clk);
		arvalid = 1'b0;
		do @(posedge clk); while (!rvalid);
		data = rdata;
		resp = rresp;
		@(negedge clk);
		rready = 1'b0;
	endtask

	task automatic write_ok(input reg_addr_t addr, input reg_data_t data);
		axi_resp_e resp;
		axi_write(addr, data, resp);
		check_resp($sformatf("write to %h", addr), RESP_OKAY, resp);
	endtask

	// Every readable value is at most 31 bits wide, so bit 31 must read as zero.
	task automatic read_word(input reg_addr_t addr, output mix_word_t word);
		axi_resp_e resp;
		reg_data_t data;
		axi_read(addr, data, resp);
		check_resp($sformatf("read from %h", addr), RESP_OKAY, resp);
		if (data[31] !== 1'b0)
			fail_now($sformatf("Read from %h in %s set bit 31.", addr, test_name));
		word = data[`MIX_WORD_W-1:0];
	endtask

	task automatic start_transfer(input block_num_t b, input mix_addr_t a, input reg_data_t ctrl);
		write_ok(reg_addr_t'(`REG_BLOCK), reg_data_t'(b));
		write_ok(reg_addr_t'(`REG_MIX_ADDR), reg_data_t'(a));
		write_ok(reg_addr_t'(`REG_CTRL), ctrl);
	endtask

	task automatic wait_idle();
		mix_word_t status;
		do
			read_word(reg_addr_t'(`REG_STATUS), status);
		while (status[0]);
	endtask

	task automatic check_block(input block_num_t b, input mix_word_t words [`BLOCK_WORDS]);
		sram_addr_t base;
		for (int i = 0; i < `BLOCK_WORDS; i++) begin
			base = block_base(b) + sram_addr_t'(2 * i);
			check_sram($sformatf("low half %0d", i), words[i][`SRAM_DATA_W-1:0],
				sram_model_i.mem[base]);
			check_sram($sformatf("high half %0d", i), {1'b0, words[i][`MIX_WORD_W-1:`SRAM_DATA_W]},
				sram_model_i.mem[base + sram_addr_t'(1)]);
		end
	endtask

	task automatic test_reg_readback();
		mix_word_t w;
		reg_data_t data;
		axi_resp_e resp;
		test_name = "register readback";
		read_word(reg_addr_t'(`REG_STATUS), w);
		check_word("STATUS after reset", '0, w);
		write_ok(reg_addr_t'(`REG_BLOCK), 32'hffff_f2a5);
		read_word(reg_addr_t'(`REG_BLOCK), w);
		check_word("BLOCK", 31'h2a5, w);
		write_ok(reg_addr_t'(`REG_MIX_ADDR), 32'h1234_5abc);
		read_word(reg_addr_t'(`REG_MIX_ADDR), w);
		check_word("MIX_ADDR", 31'habc, w);
		axi_read(16'h0010, data, resp);
		check_resp("unmapped read", RESP_SLVERR, resp);
		axi_write(16'h0020, 32'h1, resp);
		check_resp("unmapped write", RESP_SLVERR, resp);
		axi_write(reg_addr_t'(`REG_CTRL), 32'h3, resp);
		check_resp("spill and fill together", RESP_SLVERR, resp);
	endtask

	task automatic test_window();
		mix_addr_t idx [4];
		mix_word_t exp [4];
		mix_word_t w;
		logic [31:0] r;
		test_name = "window access";
		idx = '{12'd0, 12'd7, 12'd8, 12'd4095};
		for (int i = 0; i < 4; i++) begin
			r = next_random();
			exp[i] = r[`MIX_WORD_W-1:0];
			write_ok(win_addr(idx[i]), r);
		end
		for (int i = 0; i < 4; i++) begin
			read_word(win_addr(idx[i]), w);
			check_word($sformatf("word at %0d", idx[i]), exp[i], w);
		end
	endtask

	task automatic test_spill();
		logic [31:0] r;
		test_name = "spill";
		for (int i = 0; i < `BLOCK_WORDS; i++) begin
			r = next_random();
			spill_words[i] = r[`MIX_WORD_W-1:0];
			write_ok(win_addr(mix_addr_t'(20 + i)), r);
		end
		start_transfer(10'd3, 12'd20, 32'h1);
		wait_idle();
		check_block(10'd3, spill_words);
	endtask

	task automatic test_fill();
		sram_data_t even_half [`BLOCK_WORDS];
		sram_data_t odd_half [`BLOCK_WORDS];
		sram_addr_t base;
		mix_word_t w;
		test_name = "fill";
		for (int i = 0; i < `BLOCK_WORDS; i++) begin
			base = block_base(10'd5) + sram_addr_t'(2 * i);
			even_half[i] = sram_data_t'(next_random());
			odd_half[i] = sram_data_t'(next_random());
			sram_model_i.mem[base] = even_half[i];
			sram_model_i.mem[base + sram_addr_t'(1)] = odd_half[i];
		end
		start_transfer(10'd5, 12'd100, 32'h2);
		wait_idle();
		for (int i = 0; i < `BLOCK_WORDS; i++) begin
			read_word(win_addr(mix_addr_t'(100 + i)), w);
			check_word($sformatf("word %0d", i), {odd_half[i][14:0], even_half[i]}, w);
		end
	endtask

	task automatic test_busy_reject();
		axi_resp_e resp;
		test_name = "busy rejection";
		start_transfer(10'd7, 12'd20, 32'h1);
		axi_write(reg_addr_t'(`REG_CTRL), 32'h1, resp);
		check_resp("CTRL write while busy", RESP_SLVERR, resp);
		wait_idle();
		check_block(10'd7, spill_words);
	endtask

	task automatic test_round_trip();
		block_num_t b;
		mix_addr_t a;
		mix_word_t words [`BLOCK_WORDS];
		mix_word_t w;
		logic [31:0] r;
		test_name = "round trip";
		b = block_num_t'(next_random());
		a = mix_addr_t'(next_random());
		for (int i = 0; i < `BLOCK_WORDS; i++) begin
			r = next_random();
			words[i] = r[`MIX_WORD_W-1:0];
			write_ok(win_addr(mix_addr_t'(a + i)), r);
		end
		start_transfer(b, a, 32'h1);
		wait_idle();
		for (int i = 0; i < `BLOCK_WORDS; i++)
			write_ok(win_addr(mix_addr_t'(a + i)), 32'h0);
		start_transfer(b, a, 32'h2);
		wait_idle();
		for (int i = 0; i < `BLOCK_WORDS; i++) begin
			read_word(win_addr(mix_addr_t'(a + i)), w);
			check_word($sformatf("word %0d", i), words[i], w);
		end
	endtask

	initial begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("Timeout: the tests did not finish within %0d clock cycles.", TIMEOUT_CYCLES);
		$display("Finished with errors");
		$fatal(1, "Watchdog expired.");
	end

	initial begin
		rng_state = 32'ha57209be;
		test_name = "reset";
		reset = 1'b1;
		awaddr = '0;
		awvalid = 1'b0;
		wdata = '0;
		wstrb = '0;
		wvalid = 1'b0;
		bready = 1'b0;
		araddr = '0;
		arvalid = 1'b0;
		rready = 1'b0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		test_reg_readback();
		test_window();
		test_spill();
		test_fill();
		test_busy_reject();
		test_round_trip();
		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

//--- sources.f
+incdir+logic
logic/sram_pkg.sv
logic/mix_pkg.sv
logic/block_mover.sv
logic/mix_buffer.sv
logic/spill_regs.sv
logic/mix_spill_top.sv
tests/tb_clock.sv
tests/sram_model.sv
tests/mix_spill_tb.sv

//--- Makefile
VERILATOR ?= verilator
FILELIST ?= sources.f
TB_TOP ?= mix_spill_tb
RTL_TOP ?= mix_spill_top
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= Finished with no errors
VFLAGS ?=

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only --timing $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

build:
	$(VERILATOR) --binary --timing $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		-Mdir $(BUILD_DIR) -o $(TB_TOP)

sim: build
	./$(BUILD_DIR)/$(TB_TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
